/* bench/rnd_vec_model.svh */
`ifndef RND_VEC_MODEL_SVH
`define RND_VEC_MODEL_SVH

// reference copies of the two banks, index 0 is the newest word
rnd_word_t m_main  [LFSR_LENGTH];
rnd_word_t m_store [LFSR_LENGTH];

logic [31:0] lfsr_state = 32'heb0e_7518; // random source for table draws

// galois lfsr, one step per bit handed out
function automatic int rand_bits(input int n);
	int v;
	v = 0;
	for (int i = 0; i < n; i++) begin
		v = (v << 1) | int'(lfsr_state[0]); // take the low bit
		if (lfsr_state[0]) begin
			lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
		end else begin
			lfsr_state = lfsr_state >> 1;
		end
	end
	return v;
endfunction

// both banks zero, as after reset
task automatic model_reset();
	for (int i = 0; i < LFSR_LENGTH; i++) begin
		m_main[i]  = '0;
		m_store[i] = '0;
	end
endtask

// one additive lagged step
task automatic model_step();
	rnd_word_t sum;
	logic      any_lsb;
	any_lsb = 1'b0;
	for (int i = 0; i < LFSR_LENGTH; i++) begin
		any_lsb = any_lsb | m_main[i][0];
	end
	sum = m_main[LFSR_LENGTH-1] + m_main[LFSR_FEEDBACK-1]; // last word plus tap word
	if (!any_lsb) begin
		sum[0] = 1'b1; // stall guard
	end
	for (int i = LFSR_LENGTH - 1; i > 0; i--) begin
		m_main[i] = m_main[i-1];
	end
	m_main[0] = sum;
endtask

// effect of one whole host command on the banks
task automatic model_apply(input rnd_op_t op, input int len);
	case (op)
		op_init: begin
			for (int i = 0; i < LFSR_LENGTH; i++) begin
				m_main[i] = '0;
			end
			m_main[0] = rnd_word_t'(1); // seed word
			repeat (len) begin
				model_step(); // warm-up, one per extra init cycle
			end
		end
		op_next: begin
			model_step();
		end
		op_save: begin
			for (int i = 0; i < LFSR_LENGTH; i++) begin
				m_store[i] = m_main[i];
			end
		end
		default: begin
			for (int i = 0; i < LFSR_LENGTH; i++) begin
				m_main[i] = m_store[i]; // restore
			end
		end
	endcase
endtask

`endif

/* bench/rnd_vec_tb.sv */
`default_nettype none

module rnd_vec_tb
	import rnd_pkg::*;
();

	logic      clk;
	logic      arst_n;
	logic      req;
	rnd_cmd_t  cmd;
	logic      ack;
	rnd_word_t word;

	// stimulus table, one row per entry
	string   tbl_name [$];
	rnd_op_t tbl_op   [$];
	int      tbl_len  [$]; // init length, ignored for other ops
	int      tbl_rep  [$]; // handshakes for this entry

	int checks      = 0;
	int value_errs  = 0;
	int proto_errs  = 0;
	int cycle_cnt   = 0;
	int cycle_limit = 1000000; // replaced once the table exists

	// replay tracking, 0 idle, 1 after an init, 2 after a save
	int        rec_kind = 0;
	int        rec_len  = 0;
	rnd_word_t rec_q  [$]; // dut words seen since the mark
	rnd_word_t play_q [$]; // words the next commands must repeat

	`include "rnd_vec_model.svh"

	rnd_vec_top rnd_vec_top_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.req    (req),
		.cmd    (cmd),
		.ack    (ack),
		.word   (word)
	);

	always #20 clk = ~clk; // 40 unit period

	// watchdog
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout, the run did not finish within %0d cycles", cycle_limit);
			$display("*** FAILED ***");
			$finish;
		end
	end

	task automatic add_entry(input string name, input rnd_op_t op, input int len, input int rep);
		tbl_name.push_back(name);
		tbl_op.push_back(op);
		tbl_len.push_back(len);
		tbl_rep.push_back(rep);
	endtask

	task automatic report_value(input string name, input string what, input int exp, input int act);
		value_errs++;
		$display("CHECK FAILED %s %s: expected 'h%0h, actual 'h%0h", name, what, exp, act);
	endtask

	task automatic report_protocol(input string name, input string what);
		proto_errs++;
		$display("protocol error in %s, %s", name, what);
	endtask

	task automatic build_table();
		int r;
		int n;
		add_entry("init_zero", op_init, 0, 1);
		add_entry("restore_empty_store", op_restore, 0, 1); // word back to 0
		add_entry("next_from_zero", op_next, 0, 8);          // guard makes these nonzero
		add_entry("init_five", op_init, 5, 1);
		add_entry("next_after_five", op_next, 0, 16);
		add_entry("init_five_again", op_init, 5, 1);
		add_entry("next_after_five_again", op_next, 0, 16);
		r = rand_bits(6);
		n = rand_bits(4) + 4;
		add_entry("init_rand_a", op_init, r, 1);
		add_entry("next_rand_a", op_next, 0, n);
		add_entry("init_rand_a_again", op_init, r, 1);
		add_entry("next_rand_a_again", op_next, 0, n);
		add_entry("init_rand_b", op_init, rand_bits(7), 1);
		add_entry("init_long", op_init, 200, 1);
		add_entry("init_zero_long", op_init, 0, 1);
		add_entry("next_long_run", op_next, 0, 150); // well past the tap and last word
		add_entry("save_point", op_save, 0, 1);
		add_entry("next_before_restore", op_next, 0, 12);
		add_entry("restore_point", op_restore, 0, 1);
		add_entry("next_replay", op_next, 0, 12);
		add_entry("save_repeat", op_save, 0, 3);
		add_entry("init_rand_c", op_init, rand_bits(8), 2);
		add_entry("next_rand_c", op_next, 0, rand_bits(5) + 1);
	endtask

	// same init length or a restore must bring back the recorded words
	task automatic track_replay(input string name, input rnd_op_t op, input int len);
		rnd_word_t first;
		if (op == op_next) begin
			if (play_q.size() > 0) begin
				first = play_q.pop_front();
				checks++;
				if (word != first) begin
					report_value(name, "replayed word", int'(first), int'(word));
				end
			end else if (rec_kind != 0) begin
				rec_q.push_back(word); // what the dut gave after the mark
			end
		end else begin
			play_q.delete();
			if (op == op_init && rec_kind == 1 && rec_len == len) begin
				play_q   = rec_q; // same start state as before
				rec_kind = 0;
			end else if (op == op_restore && rec_kind == 2) begin
				play_q   = rec_q;
				rec_kind = 0;
			end else if (op == op_init || op == op_save) begin
				rec_q.delete();
				rec_kind = (op == op_init) ? 1 : 2;
				rec_len  = len;
			end else begin
				rec_kind = 0; // restore with nothing recorded
			end
		end
	endtask

	// one four-phase handshake, entered and left on a falling edge
	task automatic run_command(input int e, input int k);
		int        lat;
		int        exp_lat;
		rnd_word_t exp_w;
		model_apply(tbl_op[e], tbl_len[e]);
		exp_w   = m_main[0];
		exp_lat = (tbl_op[e] == op_init) ? tbl_len[e] + 2 : 2;
		cmd.op       = tbl_op[e];
		cmd.init_len = init_len_t'(tbl_len[e]);
		req = 1'b1;
		lat = 0;
		@(negedge clk);
		while (!ack) begin
			lat++;
			@(negedge clk);
		end
		checks = checks + 2;
		if (lat != exp_lat) begin
			report_value(tbl_name[e], "ack latency", exp_lat, lat);
		end
		if (word != exp_w) begin
			report_value(tbl_name[e], "word", int'(exp_w), int'(word));
		end
		track_replay(tbl_name[e], tbl_op[e], tbl_len[e]);
		repeat ((e + k) % 3) begin // host stalls with req still high
			@(negedge clk);
			checks++;
			if (!ack) begin
				report_protocol(tbl_name[e], "ack fell while req was still high");
			end
			if (word != exp_w) begin
				report_value(tbl_name[e], "held word", int'(exp_w), int'(word));
			end
		end
		req = 1'b0;
		@(negedge clk);
		checks++;
		if (ack) begin
			report_protocol(tbl_name[e], "ack still high one cycle after req was dropped");
		end
	endtask

	initial begin
		clk    = 1'b0;
		arst_n = 1'b0;
		req    = 1'b0;
		cmd    = '0;
		model_reset();
		build_table();
		cycle_limit = 64 + 8; // margin plus reset
		for (int e = 0; e < tbl_name.size(); e++) begin
			cycle_limit = cycle_limit + tbl_rep[e] * (tbl_len[e] + 6);
		end
		repeat (4) @(negedge clk); // four cycles in reset
		arst_n = 1'b1;
		@(negedge clk);
		checks = checks + 2;
		if (word != '0) begin
			report_value("reset", "word", 0, int'(word));
		end
		if (ack) begin
			report_protocol("reset", "ack high after reset");
		end
		for (int e = 0; e < tbl_name.size(); e++) begin
			for (int k = 0; k < tbl_rep[e]; k++) begin
				run_command(e, k);
			end
		end
		$display("checks %0d, value errors %0d, protocol errors %0d", checks, value_errs,
			proto_errs);
		if (value_errs == 0 && proto_errs == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* common/rnd_pkg.sv */
`default_nettype none

package rnd_pkg;

	// generator geometry
	localparam int OUT_SIZE      = 16; // bits per generated word
	localparam int LFSR_LENGTH   = 55; // words per bank
	localparam int LFSR_FEEDBACK = 24; // feedback tap, counted from 1

	// command field sizes
	localparam int INIT_LEN_W    = 8;  // init length field

	// one generated word, also the host-visible output
	typedef logic [OUT_SIZE-1:0]   rnd_word_t;

	// number of extra init cycles beyond the first
	typedef logic [INIT_LEN_W-1:0] init_len_t;

	// host command opcodes
	typedef enum logic [1:0] {
		op_init    = 2'd0, // multi-cycle init strobe
		op_next    = 2'd1, // one step
		op_save    = 2'd2, // main -> store
		op_restore = 2'd3  // store -> main
	} rnd_op_t;

	// command word presented with req
	typedef struct packed {
		rnd_op_t   op;       // what to do
		init_len_t init_len; // only meaningful for op_init
	} rnd_cmd_t;

	// command controller states
	typedef enum logic [1:0] {
		idle = 2'd0, // waiting for req
		run  = 2'd1, // strobe active
		hold = 2'd2  // ack phase, waits for req low
	} ctrl_state_t;

endpackage

`default_nettype wire

/* design/rnd_cmd_ctrl.sv */
`default_nettype none

module rnd_cmd_ctrl
	import rnd_pkg::*;
(
	input  wire           clk,
	input  wire           arst_n,
	input  wire           req,     // host request, four-phase
	input  wire rnd_cmd_t cmd,     // stable while req is high
	output logic          ack,     // host acknowledge
	output logic          init,    // init_len+1 cycles
	output logic          save,    // one cycle
	output logic          restore, // one cycle
	output logic          next     // one cycle
);

	ctrl_state_t state;
	ctrl_state_t state_nxt;

	rnd_cmd_t  cmd_q;    // command latched on accept
	init_len_t init_cnt; // init cycles still to go after this one

	logic accept;   // idle and req seen
	logic run_last; // current run cycle is the final one
	logic ack_nxt;
	logic ack_done; // host has released req after ack

	assign accept   = (state == idle) && req;
	assign ack_done = ack && !req;

	// single-cycle ops finish at once, init waits for the counter
	assign run_last = (cmd_q.op != op_init) || (init_cnt == '0);

	// next state
	always_comb begin
		state_nxt = state;
		unique case (state)
			idle: begin
				if (req) begin
					state_nxt = run;
				end
			end
			run: begin
				if (run_last) begin
					state_nxt = hold;
				end
			end
			hold: begin
				if (ack_done) begin
					state_nxt = idle; // ack drops on the same edge
				end
			end
			default: begin
				state_nxt = idle;
			end
		endcase
	end

	// ack one cycle behind hold, low again once req has fallen
	assign ack_nxt = (state == hold) && !ack_done;

	// control registers
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= idle;
			ack   <= 1'b0;
		end else begin
			state <= state_nxt;
			ack   <= ack_nxt;
		end
	end

	// init length down counter
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			init_cnt <= '0;
		end else if (accept) begin
			init_cnt <= cmd.init_len; // loaded for every op, used only by init
		end else if ((state == run) && (init_cnt != '0)) begin
			init_cnt <= init_cnt - 1'b1;
		end
	end

	// command capture, only read while in run
	always_ff @(posedge clk) begin
		if (accept) begin
			cmd_q <= cmd;
		end
	end

	// strobe decode, at most one high
	always_comb begin
		init    = 1'b0;
		save    = 1'b0;
		restore = 1'b0;
		next    = 1'b0;
		if (state == run) begin
			unique case (cmd_q.op)
				op_init: begin
					init = 1'b1; // whole run phase
				end
				op_next: begin
					next = 1'b1;
				end
				op_save: begin
					save = 1'b1;
				end
				op_restore: begin
					restore = 1'b1;
				end
				default: begin
					next = 1'b0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/rnd_vec_top.sv */
`default_nettype none

module rnd_vec_top
	import rnd_pkg::*;
(
	input  wire           clk,
	input  wire           arst_n,
	input  wire           req,  // host request
	input  wire rnd_cmd_t cmd,  // host command
	output logic          ack,  // host acknowledge
	output rnd_word_t     word  // valid while ack is high
);

	// strobes from controller to generator
	logic init_s;
	logic save_s;
	logic restore_s;
	logic next_s;

	// handshake and strobe timing
	rnd_cmd_ctrl rnd_cmd_ctrl_inst (
		.clk     (clk),
		.arst_n  (arst_n),
		.req     (req),
		.cmd     (cmd),
		.ack     (ack),
		.init    (init_s),
		.save    (save_s),
		.restore (restore_s),
		.next    (next_s)
	);

	// generator, output already settled when ack rises
	rnd_vec_gen rnd_vec_gen_inst (
		.clk     (clk),
		.arst_n  (arst_n),
		.init    (init_s),
		.save    (save_s),
		.restore (restore_s),
		.next    (next_s),
		.out     (word)
	);

endmodule

`default_nettype wire

/* rnd_vec.f */
+incdir+bench
common/rnd_pkg.sv
rnd_vec_gen/rnd_vec_gen.sv
design/rnd_cmd_ctrl.sv
design/rnd_vec_top.sv
bench/rnd_vec_tb.sv

/* rnd_vec_gen/rnd_vec_gen.sv */
`default_nettype none

module rnd_vec_gen
	import rnd_pkg::*;
(
	input  wire       clk,
	input  wire       arst_n,
	input  wire       init,    // init strobe, its length picks the start state
	input  wire       save,    // one cycle, copy main into store
	input  wire       restore, // one cycle, copy store into main
	input  wire       next,    // one cycle, advance one word
	output rnd_word_t out      // word 0 of main bank
);

	// banks, index 0 is the newest word
	rnd_word_t main_bank  [LFSR_LENGTH];
	rnd_word_t store_bank [LFSR_LENGTH];

	logic init_d; // init delayed by one cycle, for edge detect

	// step datapath
	rnd_word_t              tap_sum;   // tap word plus last word
	rnd_word_t              step_word; // word entering at position 0
	logic [LFSR_LENGTH-1:0] lsbs;      // bit 0 of every main word

	// decoded actions, init dominates, then restore, then next/save
	logic init_start;
	logic do_step;
	logic do_restore;
	logic do_save;

	assign out = main_bank[0];

	assign init_start = init && !init_d;                  // first init cycle
	assign do_step    = init ? init_d : (next && !restore); // init warm-up or next
	assign do_restore = restore && !init;
	assign do_save    = save && !init && !restore;

	// collect lowest bits for the stall guard
	always_comb begin
		for (int i = 0; i < LFSR_LENGTH; i++) begin
			lsbs[i] = main_bank[i][0];
		end
	end

	// additive lagged feedback
	assign tap_sum = main_bank[LFSR_LENGTH-1] + main_bank[LFSR_FEEDBACK-1];

	// all lsbs zero would lock the low bit forever, so force a one in
	assign step_word = {tap_sum[OUT_SIZE-1:1], (|lsbs) ? tap_sum[0] : 1'b1};

	// init edge detect register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			init_d <= 1'b0;
		end else begin
			init_d <= init;
		end
	end

	// main bank
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < LFSR_LENGTH; i++) begin
				main_bank[i] <= '0; // word reads 0 after reset
			end
		end else if (init_start) begin
			// known start point, any nonzero pattern would do
			for (int i = 1; i < LFSR_LENGTH; i++) begin
				main_bank[i] <= '0;
			end
			main_bank[0] <= rnd_word_t'(1);
		end else if (do_step) begin
			main_bank[0] <= step_word; // new word in front
			for (int i = 1; i < LFSR_LENGTH; i++) begin
				main_bank[i] <= main_bank[i-1]; // rest shifts along
			end
		end else if (do_restore) begin
			for (int i = 0; i < LFSR_LENGTH; i++) begin
				main_bank[i] <= store_bank[i];
			end
		end
	end

	// store bank, zero until the first save
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < LFSR_LENGTH; i++) begin
				store_bank[i] <= '0;
			end
		end else if (do_save) begin
			for (int i = 0; i < LFSR_LENGTH; i++) begin
				store_bank[i] <= main_bank[i]; // snapshot of current state
			end
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f rnd_vec.f --top-module rnd_vec_tb \
	-Mdir "$BUILD_DIR" -o rnd_vec_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/rnd_vec_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1
